// ==== Makefile ====
TOP = tb_vga

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f files.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== files.f ====
+incdir+hdl
hdl/vga_timing_pkg.sv
hdl/scene_pkg.sv
hdl/vga_timing.sv
hdl/ball_motion.sv
hdl/pixel_renderer.sv
hdl/vga_top.sv
testbench/vga_assertions.sv
testbench/vga_checker.sv
testbench/tb_vga.sv

// ==== hdl/ball_motion.sv ====
// ball motion
// three bouncing balls stepped once per frame at the start of vertical
// blanking, with wall reflection and tracking of the last ball to bounce
`timescale 1ns/1ps
`default_nettype none
`include "vga_macros.svh"

module ball_motion
    import vga_timing_pkg::*;
    import scene_pkg::*;
(
    input  wire logic               pixelclk,
    input  wire logic               rst,
    input  wire logic               frame_end,
    output ball_t [`NUM_BALLS-1:0]  balls,
    output color_sel_e              border_sel
);

    // leftmost entry is the highest ball index
    localparam ball_t [`NUM_BALLS-1:0] BALL_INIT = {
        ball_t'{x: coord_t'(`BALL2_X), y: coord_t'(`BALL2_Y),
                vx: vel_t'(`BALL2_V), vy: vel_t'(`BALL2_V)},
        ball_t'{x: coord_t'(`BALL1_X), y: coord_t'(`BALL1_Y),
                vx: vel_t'(`BALL1_V), vy: vel_t'(`BALL1_V)},
        ball_t'{x: coord_t'(`BALL0_X), y: coord_t'(`BALL0_Y),
                vx: vel_t'(`BALL0_V), vy: vel_t'(`BALL0_V)}
    };

    ball_t [`NUM_BALLS-1:0] balls_q;
    ball_t [`NUM_BALLS-1:0] balls_next;
    color_sel_e             sel_q;
    color_sel_e             sel_next;

    always_comb begin
        coord_t nx;
        coord_t ny;
        logic   bounce_x;
        logic   bounce_y;
        balls_next = balls_q;
        sel_next   = sel_q;     // kept when nobody bounces
        for (int i = 0; i < `NUM_BALLS; i++) begin
            nx       = balls_q[i].x + coord_t'(balls_q[i].vx);
            ny       = balls_q[i].y + coord_t'(balls_q[i].vy);
            bounce_x = (nx < coord_t'(`X_MIN)) || (nx > coord_t'(`X_MAX));   // test on new position
            bounce_y = (ny < coord_t'(`Y_MIN)) || (ny > coord_t'(`Y_MAX));
            balls_next[i].x = nx;
            balls_next[i].y = ny;
            if (bounce_x)
                balls_next[i].vx = -balls_q[i].vx;
            if (bounce_y)
                balls_next[i].vy = -balls_q[i].vy;
            if (bounce_x || bounce_y)
                sel_next = color_sel_e'(2'(i));     // later index overrides
        end
    end

    always_ff @(posedge pixelclk) begin
        if (rst) begin
            balls_q <= BALL_INIT;
            sel_q   <= SEL_WHITE;
        end else if (frame_end) begin
            balls_q <= balls_next;
            sel_q   <= sel_next;
        end
    end

    assign balls      = balls_q;
    assign border_sel = sel_q;

endmodule

`default_nettype wire

// ==== hdl/pixel_renderer.sv ====
// pixel renderer
// stage 1 registers ball and border hits for the current position,
// stage 2 resolves priority, blanks outside the visible area and registers
// rgb together with the delayed syncs
`timescale 1ns/1ps
`default_nettype none
`include "vga_macros.svh"

module pixel_renderer
    import vga_timing_pkg::*;
    import scene_pkg::*;
(
    input  wire logic                   pixelclk,
    input  wire logic                   rst,
    input  wire pixel_pos_t             pos,
    input  wire sync_t                  sync,
    input  wire ball_t [`NUM_BALLS-1:0] balls,
    input  wire color_sel_e             border_sel,
    output rgb_t                        rgb,
    output logic                        hsync,
    output logic                        vsync
);

    logic [`NUM_BALLS-1:0]  hit_q;
    logic                   border_q;
    sync_t                  sync_q;
    rgb_t                   color;

    function automatic logic in_ball(pixel_pos_t p, ball_t b);
        logic signed [26:0] dx;
        logic signed [26:0] dy;
        dx = 27'(p.x) - 27'(b.x);
        dy = 27'(p.y) - 27'(b.y);
        return (dx * dx + dy * dy) < 27'(`BALL_RADIUS * `BALL_RADIUS);
    endfunction

    // four bands framing the lower part of the screen
    function automatic logic on_border(pixel_pos_t p);
        logic in_frame;
        logic in_band;
        in_frame = (p.x < coord_t'(`H_ACTIVE)) && (p.y >= coord_t'(`BORDER_TOP))
                   && (p.y < coord_t'(`V_ACTIVE));
        in_band  = (p.y < coord_t'(`BORDER_TOP + `BORDER_THICK))
                   || (p.y >= coord_t'(`V_ACTIVE - `BORDER_THICK))
                   || (p.x < coord_t'(`BORDER_THICK))
                   || (p.x >= coord_t'(`H_ACTIVE - `BORDER_THICK));
        return in_frame && in_band;
    endfunction

    function automatic rgb_t sel_rgb(color_sel_e sel);
        case (sel)
            SEL_RED:   return rgb_t'(3'b100);
            SEL_GREEN: return rgb_t'(3'b010);
            SEL_BLUE:  return rgb_t'(3'b001);
            default:   return rgb_t'(3'b111);
        endcase
    endfunction

    always_ff @(posedge pixelclk) begin
        for (int i = 0; i < `NUM_BALLS; i++)
            hit_q[i] <= in_ball(pos, balls[i]);
        border_q <= on_border(pos);
    end

    always_ff @(posedge pixelclk) begin
        if (rst)
            sync_q <= '{hsync: 1'b1, vsync: 1'b1, active: 1'b0};
        else
            sync_q <= sync;
    end

    // lowest ball index on top, then border, then black
    always_comb begin
        color = '0;
        if (border_q)
            color = sel_rgb(border_sel);
        for (int i = `NUM_BALLS - 1; i >= 0; i--)
            if (hit_q[i])
                color = sel_rgb(color_sel_e'(2'(i)));
        if (!sync_q.active)
            color = '0;
    end

    always_ff @(posedge pixelclk) begin
        if (rst) begin
            rgb   <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            rgb   <= color;
            hsync <= sync_q.hsync;  // second delay stage, aligned with rgb
            vsync <= sync_q.vsync;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/scene_pkg.sv ====
// scene types
// ball state, per-pixel colour and the border colour selection
`default_nettype none

package scene_pkg;

    import vga_timing_pkg::*;

    typedef logic signed [4:0] vel_t;   // step per frame update

    typedef struct packed {
        coord_t x;      // centre
        coord_t y;
        vel_t   vx;
        vel_t   vy;
    } ball_t;

    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } rgb_t;

    // the first three codes match the ball index
    typedef enum logic [1:0] {
        SEL_RED,
        SEL_GREEN,
        SEL_BLUE,
        SEL_WHITE
    } color_sel_e;

endpackage

`default_nettype wire

// ==== hdl/vga_macros.svh ====
// vga test pattern constants
// display timing, ball geometry, bounce limits and border rectangles
`ifndef VGA_MACROS_SVH
`define VGA_MACROS_SVH

`define H_ACTIVE        1024    // visible pixels per line
`define H_FRONT_END     1048    // hsync starts here
`define H_SYNC_END      1184
`define H_TOTAL         1328

`define V_ACTIVE        768     // visible lines per frame
`define V_FRONT_END     770     // vsync starts here
`define V_SYNC_END      776
`define V_TOTAL         806

`define BALL_RADIUS     50
`define X_MIN           50      // bounce limits on the ball centre
`define X_MAX           964
`define Y_MIN           261
`define Y_MAX           708

`define BORDER_TOP      200     // first line of the top band
`define BORDER_THICK    10

`define NUM_BALLS       3
`define RENDER_LATENCY  2       // position to rgb, in pixel clocks

`define BALL0_X         60
`define BALL0_Y         300
`define BALL0_V         2
`define BALL1_X         600
`define BALL1_Y         500
`define BALL1_V         3
`define BALL2_X         400
`define BALL2_Y         700
`define BALL2_V         4

`endif

// ==== hdl/vga_timing.sv ====
// vga raster timing
// horizontal and vertical counters for a 1328 x 806 raster, registered
// sync levels, active flag and a one-cycle strobe at the end of the last
// visible line
`timescale 1ns/1ps
`default_nettype none
`include "vga_macros.svh"

module vga_timing
    import vga_timing_pkg::*;
(
    input  wire logic   pixelclk,
    input  wire logic   rst,
    output pixel_pos_t  pos,
    output sync_t       sync,
    output logic        frame_end
);

    coord_t     h_count;
    coord_t     v_count;
    coord_t     v_next;
    h_region_e  region;
    h_region_e  region_next;
    logic       line_end;
    logic       hsync_q;
    logic       vsync_q;
    logic       v_active_q;     // tracks v_count < V_ACTIVE

    assign line_end = (h_count == coord_t'(`H_TOTAL - 1));
    assign v_next   = !line_end ? v_count :
                      (v_count == coord_t'(`V_TOTAL - 1)) ? '0 : v_count + coord_t'(1);

    // region follows the counter, switching on the last pixel of each region
    always_comb begin
        region_next = region;
        case (region)
            ACTIVE: if (h_count == coord_t'(`H_ACTIVE - 1))
                region_next = FRONT;
            FRONT: if (h_count == coord_t'(`H_FRONT_END - 1))
                region_next = SYNC;
            SYNC: if (h_count == coord_t'(`H_SYNC_END - 1))
                region_next = BACK;
            BACK: if (line_end)
                region_next = ACTIVE;
            default: region_next = ACTIVE;
        endcase
    end

    always_ff @(posedge pixelclk) begin
        if (rst) begin
            h_count    <= '0;
            v_count    <= '0;
            region     <= ACTIVE;
            hsync_q    <= 1'b1;
            vsync_q    <= 1'b1;
            v_active_q <= 1'b1;
        end else begin
            h_count    <= line_end ? '0 : h_count + coord_t'(1);
            v_count    <= v_next;
            region     <= region_next;
            hsync_q    <= (region_next != SYNC);
            vsync_q    <= !(v_next >= coord_t'(`V_FRONT_END) && v_next < coord_t'(`V_SYNC_END));
            v_active_q <= (v_next < coord_t'(`V_ACTIVE));
        end
    end

    assign pos       = '{x: h_count, y: v_count};
    assign sync      = '{hsync: hsync_q, vsync: vsync_q, active: (region == ACTIVE) && v_active_q};
    assign frame_end = line_end && (v_count == coord_t'(`V_ACTIVE - 1));   // start of vblank

endmodule

`default_nettype wire

// ==== hdl/vga_timing_pkg.sv ====
// raster types
// screen coordinates, pixel position, sync bundle and horizontal region
`default_nettype none

package vga_timing_pkg;

    typedef logic signed [11:0] coord_t;    // fits 0..1327 with room for signed math

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pixel_pos_t;

    typedef struct packed {
        logic hsync;    // active low
        logic vsync;    // active low
        logic active;   // inside the visible area
    } sync_t;

    // where the horizontal counter sits within a line
    typedef enum logic [1:0] {
        ACTIVE,
        FRONT,
        SYNC,
        BACK
    } h_region_e;

endpackage

`default_nettype wire

// ==== hdl/vga_top.sv ====
// vga test pattern top level
// raster timing feeds the ball motion and the two-stage pixel renderer
`timescale 1ns/1ps
`default_nettype none
`include "vga_macros.svh"

module vga_top
    import vga_timing_pkg::*;
    import scene_pkg::*;
(
    input  wire logic   pixelclk,
    input  wire logic   rst,
    output rgb_t        rgb,
    output logic        hsync,
    output logic        vsync
);

    pixel_pos_t             pos;
    sync_t                  sync;
    logic                   frame_end;
    ball_t [`NUM_BALLS-1:0] balls;
    color_sel_e             border_sel;

    vga_timing u_timing (
        .pixelclk  (pixelclk),
        .rst       (rst),
        .pos       (pos),
        .sync      (sync),
        .frame_end (frame_end)
    );

    ball_motion u_motion (
        .pixelclk   (pixelclk),
        .rst        (rst),
        .frame_end  (frame_end),
        .balls      (balls),
        .border_sel (border_sel)
    );

    pixel_renderer u_renderer (
        .pixelclk   (pixelclk),
        .rst        (rst),
        .pos        (pos),
        .sync       (sync),
        .balls      (balls),
        .border_sel (border_sel),
        .rgb        (rgb),
        .hsync      (hsync),
        .vsync      (vsync)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_vga.sv ====
// vga test pattern testbench
// clock and reset, a sorted table of colour probes handed one by one to the
// checker, a cycle watchdog and the final verdict
`timescale 1ns/1ps
`default_nettype none
`include "vga_macros.svh"

module tb_vga
    import vga_timing_pkg::*;
    import scene_pkg::*;
();

    localparam int RESET_CYCLES   = 5;
    localparam int RANDOM_PROBES  = 6;
    localparam int CLEARANCE      = 60;     // background probe distance from any ball
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + (42 * `H_TOTAL * `V_TOTAL) / 10;

    typedef struct packed {
        int   frame;
        int   x;
        int   y;
        rgb_t rgb;
    } probe_t;

    localparam rgb_t BLACK = rgb_t'(3'b000);
    localparam rgb_t RED   = rgb_t'(3'b100);
    localparam rgb_t GREEN = rgb_t'(3'b010);
    localparam rgb_t BLUE  = rgb_t'(3'b001);
    localparam rgb_t WHITE = rgb_t'(3'b111);

    // frame, x, y, expected colour
    localparam probe_t FIXED_PROBES [15] = '{
        '{0, 60, 300, RED},     '{0, 600, 500, GREEN},  '{0, 400, 700, BLUE},
        '{0, 500, 205, WHITE},  '{0, 500, 400, BLACK},  '{0, 1100, 300, BLACK},
        '{0, 500, 780, BLACK},  '{0, 1200, 790, BLACK}, '{1, 500, 205, WHITE},
        '{2, 606, 506, GREEN},  '{2, 600, 500, GREEN},  '{2, 554, 506, BLACK},
        '{2, 500, 205, WHITE},  '{3, 500, 205, BLUE},   '{3, 412, 712, BLUE}
    };

    logic       pixelclk;
    logic       rst;
    rgb_t       rgb;
    logic       hsync;
    logic       vsync;
    logic       probe_valid;
    logic [7:0] probe_frame;
    pixel_pos_t probe_pos;
    rgb_t       probe_rgb;
    logic       probe_done;
    int         pass_count;
    int         fail_count;
    int         frames_checked;
    int         cycle_count;
    probe_t     probes[$];

    vga_top dut (
        .pixelclk (pixelclk),
        .rst      (rst),
        .rgb      (rgb),
        .hsync    (hsync),
        .vsync    (vsync)
    );

    vga_checker u_checker (
        .pixelclk       (pixelclk),
        .rst            (rst),
        .rgb            (rgb),
        .hsync          (hsync),
        .vsync          (vsync),
        .probe_valid    (probe_valid),
        .probe_frame    (probe_frame),
        .probe_pos      (probe_pos),
        .probe_rgb      (probe_rgb),
        .probe_done     (probe_done),
        .pass_count     (pass_count),
        .fail_count     (fail_count),
        .frames_checked (frames_checked)
    );

    function automatic int raster_index(probe_t p);
        return p.frame * `H_TOTAL * `V_TOTAL + p.y * `H_TOTAL + p.x;
    endfunction

    function automatic logic index_taken(int key);
        foreach (probes[i])
            if (raster_index(probes[i]) == key)
                return 1'b1;
        return 1'b0;
    endfunction

    // frame 0 background, away from the reset ball centres and the four bands
    function automatic logic clear_of_scene(int x, int y);
        int   cx [3] = '{`BALL0_X, `BALL1_X, `BALL2_X};
        int   cy [3] = '{`BALL0_Y, `BALL1_Y, `BALL2_Y};
        logic banded;
        banded = (y >= 200) && ((y <= 209) || (y >= 758) || (x <= 9) || (x >= 1014));
        if (banded)
            return 1'b0;
        for (int i = 0; i < 3; i++)
            if ((x - cx[i]) * (x - cx[i]) + (y - cy[i]) * (y - cy[i]) < CLEARANCE * CLEARANCE)
                return 1'b0;
        return 1'b1;
    endfunction

    // probes must reach the checker in raster order
    task automatic sort_probes();
        probe_t item;
        int     j;
        for (int i = 1; i < probes.size(); i++) begin
            item = probes[i];
            j    = i - 1;
            while (j >= 0 && raster_index(probes[j]) > raster_index(item)) begin
                probes[j + 1] = probes[j];
                j--;
            end
            probes[j + 1] = item;
        end
    endtask

    task automatic run_probe(input probe_t p);
        probe_frame <= 8'(p.frame);
        probe_pos   <= '{x: coord_t'(p.x), y: coord_t'(p.y)};
        probe_rgb   <= p.rgb;
        probe_valid <= 1'b1;
        @(posedge pixelclk);
        while (!probe_done)
            @(posedge pixelclk);
    endtask

    initial begin
        pixelclk = 1'b0;
        forever #50 pixelclk = ~pixelclk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge pixelclk);
            cycle_count++;
        end
        $display("timeout: probes still pending after %0d clock cycles", cycle_count);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        probe_t cand;
        int     tries;
        rst         = 1'b1;
        probe_valid = 1'b0;
        probe_frame = '0;
        probe_pos   = '0;
        probe_rgb   = '0;
        void'($urandom(32'h766a_530b));
        foreach (FIXED_PROBES[i])
            probes.push_back(FIXED_PROBES[i]);
        tries = 0;
        while (probes.size() < $size(FIXED_PROBES) + RANDOM_PROBES && tries < 1000) begin
            cand.frame = 0;
            cand.x     = int'($urandom % `H_ACTIVE);
            cand.y     = int'($urandom % `V_ACTIVE);
            cand.rgb   = BLACK;
            if (clear_of_scene(cand.x, cand.y) && !index_taken(raster_index(cand)))
                probes.push_back(cand);
            tries++;
        end
        sort_probes();

        repeat (RESET_CYCLES) @(posedge pixelclk);
        rst <= 1'b0;
        foreach (probes[i])
            run_probe(probes[i]);
        probe_valid <= 1'b0;

        if (dut.u_renderer.u_assert.failures != 0)
            $display("%0d assertion failures on the renderer outputs",
                     dut.u_renderer.u_assert.failures);
        if (frames_checked < 3)
            $display("sync timing was checked on only %0d frames", frames_checked);
        if (u_checker.frame_errs != 0)
            $display("%0d sync errors in the unfinished last frame", u_checker.frame_errs);
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && frames_checked >= 3 && u_checker.frame_errs == 0
            && dut.u_renderer.u_assert.failures == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/vga_assertions.sv ====
// renderer assertions
// sync and blanking rules on the registered outputs of the pixel renderer
`timescale 1ns/1ps
`default_nettype none
`include "vga_macros.svh"

module vga_assertions
    import vga_timing_pkg::*;
    import scene_pkg::*;
(
    input wire logic       pixelclk,
    input wire logic       rst,
    input wire pixel_pos_t pos,
    input wire sync_t      sync_q,
    input wire rgb_t       rgb,
    input wire logic       hsync,
    input wire logic       vsync
);

    int   failures = 0;     // read by the testbench at the end of the run
    logic outside;          // position beyond the visible area

    assign outside = (pos.x >= coord_t'(`H_ACTIVE)) || (pos.y >= coord_t'(`V_ACTIVE));

    // rgb trails the position by the render latency
    blank_outside_active: assert property (@(posedge pixelclk) disable iff (rst)
        $past(outside, `RENDER_LATENCY) |-> (rgb == '0))
        else begin
            $error("rgb not blank outside the visible area");
            failures++;
        end

    syncs_idle_in_active: assert property (@(posedge pixelclk) disable iff (rst)
        sync_q.active |-> (sync_q.hsync && sync_q.vsync))
        else begin
            $error("sync pulse inside the visible area");
            failures++;
        end

    no_colour_in_sync: assert property (@(posedge pixelclk) disable iff (rst)
        (!hsync || !vsync) |-> (rgb == '0))
        else begin
            $error("rgb not blank during a sync pulse");
            failures++;
        end

endmodule

bind pixel_renderer vga_assertions u_assert (
    .pixelclk (pixelclk),
    .rst      (rst),
    .pos      (pos),
    .sync_q   (sync_q),
    .rgb      (rgb),
    .hsync    (hsync),
    .vsync    (vsync)
);

`default_nettype wire

// ==== testbench/vga_checker.sv ====
// raster checker
// rebuilds the position of each rgb sample from the cycle count after reset,
// compares requested probes and checks sync pulse positions, widths and periods
`timescale 1ns/1ps
`default_nettype none
`include "vga_macros.svh"

module vga_checker
    import vga_timing_pkg::*;
    import scene_pkg::*;
(
    input  wire logic       pixelclk,
    input  wire logic       rst,
    input  wire rgb_t       rgb,
    input  wire logic       hsync,
    input  wire logic       vsync,
    input  wire logic       probe_valid,
    input  wire logic [7:0] probe_frame,
    input  wire pixel_pos_t probe_pos,
    input  wire rgb_t       probe_rgb,
    output logic            probe_done,
    output int              pass_count,
    output int              fail_count,
    output int              frames_checked
);

    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;

    int   cycle;        // pixel clocks since reset release
    int   idx;
    int   cur_x;
    int   cur_y;
    int   cur_frame;
    int   h_fall;
    int   v_fall;
    int   h_pulses;
    int   frame_errs;
    logic prev_hsync;
    logic prev_vsync;

    task automatic flag_mismatch(input string name, input int got, input int exp);
        $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, got);
        frame_errs++;
    endtask

    task automatic check_probe();
        if (rgb == probe_rgb) begin
            $display("probe frame %0d (%0d, %0d): rgb %b as expected",
                     cur_frame, cur_x, cur_y, rgb);
            pass_count++;
        end else begin
            $display("CHECK FAILED at %0t: rgb at frame %0d (%0d, %0d) expected %b got %b",
                     $time, cur_frame, cur_x, cur_y, probe_rgb, rgb);
            fail_count++;
        end
    endtask

    task automatic check_syncs();
        int exp_pulses;
        if (prev_hsync && !hsync) begin
            if (cur_x != `H_FRONT_END)
                flag_mismatch("hsync fall x", cur_x, `H_FRONT_END);
            if (h_fall >= 0 && cycle - h_fall != `H_TOTAL)
                flag_mismatch("hsync period", cycle - h_fall, `H_TOTAL);
            h_fall = cycle;
            h_pulses++;
        end
        if (!prev_hsync && hsync && cycle - h_fall != `H_SYNC_END - `H_FRONT_END)
            flag_mismatch("hsync width", cycle - h_fall, `H_SYNC_END - `H_FRONT_END);
        if (prev_vsync && !vsync) begin
            if (cur_y != `V_FRONT_END)
                flag_mismatch("vsync fall y", cur_y, `V_FRONT_END);
            if (cur_x != 0)
                flag_mismatch("vsync fall x", cur_x, 0);
            if (v_fall >= 0 && cycle - v_fall != FRAME_CYCLES)
                flag_mismatch("vsync period", cycle - v_fall, FRAME_CYCLES);
            v_fall = cycle;
        end
        if (!prev_vsync && vsync) begin
            if (cycle - v_fall != (`V_SYNC_END - `V_FRONT_END) * `H_TOTAL)
                flag_mismatch("vsync width", cycle - v_fall,
                              (`V_SYNC_END - `V_FRONT_END) * `H_TOTAL);
            // first frame counts from line 0, later ones from the end of vsync
            exp_pulses = (frames_checked == 0) ? `V_SYNC_END : `V_TOTAL;
            if (h_pulses != exp_pulses)
                flag_mismatch("hsync pulses per frame", h_pulses, exp_pulses);
            // end of vsync closes the timing test of this frame
            if (frame_errs == 0) begin
                $display("frame %0d sync timing: %0d hsync pulses, widths and periods correct",
                         cur_frame, h_pulses);
                pass_count++;
            end else begin
                $display("frame %0d sync timing: %0d errors found", cur_frame, frame_errs);
                fail_count++;
            end
            frames_checked++;
            frame_errs = 0;
            h_pulses   = 0;
        end
    endtask

    always @(negedge pixelclk) begin
        if (rst) begin
            cycle          = 0;
            h_fall         = -1;
            v_fall         = -1;
            h_pulses       = 0;
            frame_errs     = 0;
            prev_hsync     = 1'b1;
            prev_vsync     = 1'b1;
            pass_count     = 0;
            fail_count     = 0;
            frames_checked = 0;
            probe_done    <= 1'b0;
        end else begin
            idx = cycle - `RENDER_LATENCY;  // rgb trails the counters
            probe_done <= 1'b0;
            if (idx >= 0) begin
                cur_x     = idx % `H_TOTAL;
                cur_y     = (idx / `H_TOTAL) % `V_TOTAL;
                cur_frame = idx / FRAME_CYCLES;
                if (probe_valid && cur_frame == int'(probe_frame)
                    && cur_x == int'(probe_pos.x) && cur_y == int'(probe_pos.y)) begin
                    check_probe();
                    probe_done <= 1'b1;
                end
                check_syncs();
            end
            prev_hsync = hsync;
            prev_vsync = vsync;
            cycle++;
        end
    end

endmodule

`default_nettype wire
